//--- include/ddc_defs.svh
`ifndef DDC_DEFS_SVH
`define DDC_DEFS_SVH

// width of one I or Q component.
`define DDC_DATA_W 16

// phase accumulator, increment and offset width.
`define DDC_PHASE_W 14

// top phase bits used as table address.
`define DDC_LUT_W 10

// peak oscillator value.
`define DDC_AMP 32767

// decimation exponent width, factor is 2^k.
`define DDC_DEC_W 3

// room for 2^7 summed samples.
`define DDC_ACC_W 23

`endif

//--- source/ddc_pkg.sv
`include "ddc_defs.svh"

package ddc_pkg;

    localparam int IQ_W        = `DDC_DATA_W;
    localparam int RND_IN_W    = 40;
    localparam int RND_SHIFT_W = 5;
    localparam int SAT_MAX     = (1 << (IQ_W - 1)) - 1;
    localparam int SAT_MIN     = -(1 << (IQ_W - 1));

    typedef struct packed {
        logic signed [IQ_W-1:0] i;
        logic signed [IQ_W-1:0] q;
    } iq_sample_t;

    typedef struct packed {
        logic signed [IQ_W-1:0] cos_v;
        logic signed [IQ_W-1:0] sin_v;
    } lo_sample_t;

    // code 3 falls back to truncation.
    typedef enum logic [1:0] {
        RND_TRUNC     = 2'd0,
        RND_HALF_UP   = 2'd1,
        RND_HALF_EVEN = 2'd2
    } round_mode_e;

    function automatic logic signed [IQ_W-1:0] ddc_round_sat(
        input logic signed [RND_IN_W-1:0] value,
        input logic [RND_SHIFT_W-1:0]     shift,
        input round_mode_e                mode
    );
        logic        [RND_IN_W-1:0] mask;
        logic        [RND_IN_W-1:0] frac;
        logic        [RND_IN_W-1:0] half;
        logic signed [RND_IN_W-1:0] floor_v;
        logic signed [RND_IN_W-1:0] rounded;

        mask    = ~({RND_IN_W{1'b1}} << shift);
        frac    = value & mask;
        half    = (mask >> 1) + 1'b1;
        floor_v = value >>> shift;
        rounded = floor_v;

        if (shift != '0) begin
            case (mode)
                RND_HALF_UP: begin
                    rounded = (value + $signed(half)) >>> shift;
                end
                RND_HALF_EVEN: begin
                    // ties go to the even neighbour.
                    if (frac > half || (frac == half && floor_v[0])) begin
                        rounded = floor_v + 1;
                    end
                end
                default: begin
                    rounded = floor_v;
                end
            endcase
        end

        if (rounded > SAT_MAX) begin
            return IQ_W'(SAT_MAX);
        end
        if (rounded < SAT_MIN) begin
            return IQ_W'(SAT_MIN);
        end
        return rounded[IQ_W-1:0];
    endfunction

endpackage

//--- source/ddc_nco.sv
`timescale 1ns/100ps
`include "ddc_defs.svh"

module ddc_nco (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    en_i,
    input  logic [`DDC_PHASE_W-1:0] phase_inc_i,
    input  logic [`DDC_PHASE_W-1:0] phase_offset_i,
    input  logic                    tvalid_i,
    output logic                    lo_valid_o,
    output ddc_pkg::lo_sample_t     lo_data_o
);

    import ddc_pkg::*;

    localparam int  PHASE_W   = `DDC_PHASE_W;
    localparam int  LUT_W     = `DDC_LUT_W;
    localparam int  LUT_DEPTH = 1 << LUT_W;
    localparam real PI        = 3.14159265358979323846;

    typedef logic signed [IQ_W-1:0] cos_table_t [LUT_DEPTH];

    // one full cosine period, nearest integer.
    function automatic cos_table_t build_cos_table();
        cos_table_t tbl;
        real        val;

        for (int j = 0; j < LUT_DEPTH; j++) begin
            val = `DDC_AMP * $cos(2.0 * PI * j / LUT_DEPTH);
            if (val >= 0.0) begin
                tbl[j] = IQ_W'($rtoi(val + 0.5));
            end else begin
                tbl[j] = IQ_W'(-$rtoi(0.5 - val));
            end
        end
        return tbl;
    endfunction

    localparam cos_table_t COS_TABLE = build_cos_table();

    logic [PHASE_W-1:0] phase_acc;
    logic [PHASE_W-1:0] phase_sum;
    logic [LUT_W-1:0]   cos_idx;
    logic [LUT_W-1:0]   sin_idx;
    lo_sample_t         lo_next;

    assign phase_sum = phase_acc + phase_offset_i;
    assign cos_idx   = phase_sum[PHASE_W-1 -: LUT_W];
    // sine is the cosine a quarter turn back.
    assign sin_idx   = cos_idx - LUT_W'(LUT_DEPTH / 4);

    always_comb begin
        lo_next.cos_v = COS_TABLE[cos_idx];
        lo_next.sin_v = COS_TABLE[sin_idx];
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase_acc  <= '0;
            lo_valid_o <= 1'b0;
        end else if (!en_i) begin
            phase_acc  <= '0;
            lo_valid_o <= 1'b0;
        end else begin
            lo_valid_o <= tvalid_i;
            if (tvalid_i) begin
                phase_acc <= phase_acc + phase_inc_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (tvalid_i) begin
            lo_data_o <= lo_next;
        end
    end

endmodule

//--- source/ddc_mixer.sv
`timescale 1ns/100ps
`include "ddc_defs.svh"

module ddc_mixer (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 en_i,
    input  ddc_pkg::round_mode_e round_mode_i,
    input  logic                 tvalid_i,
    input  ddc_pkg::iq_sample_t  tdata_i,
    input  logic                 lo_valid_i,
    input  ddc_pkg::lo_sample_t  lo_data_i,
    output logic                 mix_valid_o,
    output ddc_pkg::iq_sample_t  mix_data_o
);

    import ddc_pkg::*;

    localparam int PROD_W    = 2 * IQ_W;
    // drop the oscillator's Q15 scale.
    localparam int MIX_SHIFT = IQ_W - 1;

    iq_sample_t                 x_d;
    logic signed [PROD_W-1:0]   p_ic;
    logic signed [PROD_W-1:0]   p_qs;
    logic signed [PROD_W-1:0]   p_qc;
    logic signed [PROD_W-1:0]   p_is;
    logic signed [RND_IN_W-1:0] sum_i;
    logic signed [RND_IN_W-1:0] sum_q;
    iq_sample_t                 mix_next;

    // hold the sample one cycle to meet its oscillator value.
    always_ff @(posedge clk_i) begin
        if (tvalid_i) begin
            x_d <= tdata_i;
        end
    end

    // multiply by the conjugate oscillator.
    always_comb begin
        p_ic  = x_d.i * lo_data_i.cos_v;
        p_qs  = x_d.q * lo_data_i.sin_v;
        p_qc  = x_d.q * lo_data_i.cos_v;
        p_is  = x_d.i * lo_data_i.sin_v;
        sum_i = RND_IN_W'(p_ic) + RND_IN_W'(p_qs);
        sum_q = RND_IN_W'(p_qc) - RND_IN_W'(p_is);

        mix_next.i = ddc_round_sat(sum_i, RND_SHIFT_W'(MIX_SHIFT), round_mode_i);
        mix_next.q = ddc_round_sat(sum_q, RND_SHIFT_W'(MIX_SHIFT), round_mode_i);
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mix_valid_o <= 1'b0;
        end else if (!en_i) begin
            mix_valid_o <= 1'b0;
        end else begin
            mix_valid_o <= lo_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (lo_valid_i) begin
            mix_data_o <= mix_next;
        end
    end

endmodule

//--- source/ddc_decimator.sv
`timescale 1ns/100ps
`include "ddc_defs.svh"

module ddc_decimator (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  en_i,
    input  ddc_pkg::round_mode_e  round_mode_i,
    input  logic [`DDC_DEC_W-1:0] decim_log2_i,
    input  logic                  mix_valid_i,
    input  ddc_pkg::iq_sample_t   mix_data_i,
    output logic                  tvalid_o,
    output ddc_pkg::iq_sample_t   tdata_o
);

    import ddc_pkg::*;

    localparam int ACC_W = `DDC_ACC_W;
    // counter spans the largest block, 2^7 samples.
    localparam int CNT_W = ACC_W - IQ_W;

    logic signed [ACC_W-1:0] acc_i;
    logic signed [ACC_W-1:0] acc_q;
    logic signed [ACC_W-1:0] sum_i;
    logic signed [ACC_W-1:0] sum_q;
    logic [CNT_W-1:0]        blk_cnt;
    logic [CNT_W-1:0]        blk_last;
    logic                    blk_done;
    iq_sample_t              avg_next;

    // index of the last sample in a block.
    assign blk_last = {CNT_W{1'b1}} >> (CNT_W - decim_log2_i);
    assign blk_done = mix_valid_i && (blk_cnt == blk_last);

    // running sum including the current sample.
    assign sum_i = acc_i + ACC_W'(mix_data_i.i);
    assign sum_q = acc_q + ACC_W'(mix_data_i.q);

    always_comb begin
        avg_next.i = ddc_round_sat(sum_i, RND_SHIFT_W'(decim_log2_i), round_mode_i);
        avg_next.q = ddc_round_sat(sum_q, RND_SHIFT_W'(decim_log2_i), round_mode_i);
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            acc_i    <= '0;
            acc_q    <= '0;
            blk_cnt  <= '0;
            tvalid_o <= 1'b0;
        end else if (!en_i) begin
            acc_i    <= '0;
            acc_q    <= '0;
            blk_cnt  <= '0;
            tvalid_o <= 1'b0;
        end else begin
            tvalid_o <= blk_done;
            if (blk_done) begin
                // dump and start the next block empty.
                acc_i   <= '0;
                acc_q   <= '0;
                blk_cnt <= '0;
            end else if (mix_valid_i) begin
                acc_i   <= sum_i;
                acc_q   <= sum_q;
                blk_cnt <= blk_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (blk_done) begin
            tdata_o <= avg_next;
        end
    end

endmodule

//--- source/ddc_top.sv
`timescale 1ns/100ps
`include "ddc_defs.svh"

module ddc_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    en_i,
    input  ddc_pkg::round_mode_e    round_mode_i,
    input  logic [`DDC_DEC_W-1:0]   decim_log2_i,
    input  logic [`DDC_PHASE_W-1:0] phase_inc_i,
    input  logic [`DDC_PHASE_W-1:0] phase_offset_i,
    input  logic                    tvalid_i,
    input  ddc_pkg::iq_sample_t     tdata_i,
    output logic                    tvalid_o,
    output ddc_pkg::iq_sample_t     tdata_o
);

    import ddc_pkg::*;

    logic       lo_valid;
    lo_sample_t lo_data;
    logic       mix_valid;
    iq_sample_t mix_data;

    ddc_nco i_nco (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .en_i          (en_i),
        .phase_inc_i   (phase_inc_i),
        .phase_offset_i(phase_offset_i),
        .tvalid_i      (tvalid_i),
        .lo_valid_o    (lo_valid),
        .lo_data_o     (lo_data)
    );

    ddc_mixer i_mixer (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .en_i        (en_i),
        .round_mode_i(round_mode_i),
        .tvalid_i    (tvalid_i),
        .tdata_i     (tdata_i),
        .lo_valid_i  (lo_valid),
        .lo_data_i   (lo_data),
        .mix_valid_o (mix_valid),
        .mix_data_o  (mix_data)
    );

    ddc_decimator i_decimator (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .en_i        (en_i),
        .round_mode_i(round_mode_i),
        .decim_log2_i(decim_log2_i),
        .mix_valid_i (mix_valid),
        .mix_data_i  (mix_data),
        .tvalid_o    (tvalid_o),
        .tdata_o     (tdata_o)
    );

endmodule

//--- verification/ddc_checker.sv
`timescale 1ns/100ps

module ddc_checker (
    input logic                clk_i,
    input logic                rst_n_i,
    input logic                en_i,
    input logic                tvalid_i,
    input logic                lo_valid_i,
    input logic                mix_valid_i,
    input logic                out_valid_i,
    input ddc_pkg::iq_sample_t out_data_i
);

    // output stays quiet while reset is held.
    a_reset_quiet: assert property (
        @(posedge clk_i) !rst_n_i |-> !out_valid_i
    ) else $error("output strobe during reset");

    // input strobe reaches the mixer output two cycles later.
    a_mix_follows_input: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (tvalid_i && en_i) ##1 en_i |=> mix_valid_i
    ) else $error("mixer strobe missing two cycles after input strobe");

    a_mix_has_source: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        mix_valid_i |-> ($past(tvalid_i, 2) && $past(en_i, 2) && $past(en_i, 1))
    ) else $error("mixer strobe without an input strobe two cycles before");

    a_out_data_known: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        out_valid_i |-> !$isunknown(out_data_i)
    ) else $error("output data has unknown bits while valid");

    // registers cleared one edge after enable drops.
    a_no_strobe_disabled: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !$past(en_i) |-> (!lo_valid_i && !mix_valid_i && !out_valid_i)
    ) else $error("strobe seen while enable was low");

endmodule

//--- verification/ddc_tb.sv
`timescale 1ns/100ps
`include "ddc_defs.svh"

module ddc_tb;

    import ddc_pkg::*;

    localparam int     PERIOD    = 100;
    localparam int     PHASE_W   = `DDC_PHASE_W;
    localparam int     LUT_W     = `DDC_LUT_W;
    localparam real    PI        = 3.14159265358979323846;
    localparam int     FULL_POS  = 32767;
    localparam int     FULL_NEG  = -32768;
    localparam int     MAX_GAP   = 3;
    localparam int     MAX_K     = 7;
    localparam int     N_ZERO    = 64;
    localparam int     N_RAND    = 128;
    localparam int     N_DEC     = 256;
    localparam int     N_SAT     = 32;
    localparam int     N_PARTIAL = 5;
    localparam int     N_RESTART = 64;
    localparam int     N_TOTAL   = 3 * N_ZERO + 6 * N_RAND + 8 * N_DEC + 3 * N_SAT
                                   + N_PARTIAL + N_RESTART;
    localparam longint TIMEOUT_NS = longint'(N_TOTAL) * (MAX_GAP + (1 << MAX_K)) * PERIOD
                                    + 2000 * PERIOD;

    logic                    clk;
    logic                    rst_n;
    logic                    en;
    round_mode_e             round_mode;
    logic [`DDC_DEC_W-1:0]   decim_log2;
    logic [PHASE_W-1:0]      phase_inc;
    logic [PHASE_W-1:0]      phase_offset;
    logic                    tvalid_in;
    iq_sample_t              tdata_in;
    logic                    tvalid_out;
    iq_sample_t              tdata_out;

    integer     seed      = 32'h2a9e_64aa;
    iq_sample_t exp_q[$];
    string      cur_test  = "reset_state";
    int         out_count = 0;
    logic       en_d      = 1'b0;
    logic       en_was;
    iq_sample_t exp_v;

    // model state cleared on every restart.
    int         model_mode;
    int         model_k;
    int         model_inc;
    int         model_off;
    int         model_phase;
    longint     blk_sum_i;
    longint     blk_sum_q;
    int         blk_n;

    ddc_top ddc_top_inst (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .en_i          (en),
        .round_mode_i  (round_mode),
        .decim_log2_i  (decim_log2),
        .phase_inc_i   (phase_inc),
        .phase_offset_i(phase_offset),
        .tvalid_i      (tvalid_in),
        .tdata_i       (tdata_in),
        .tvalid_o      (tvalid_out),
        .tdata_o       (tdata_out)
    );

    bind ddc_top ddc_checker checker_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .en_i       (en_i),
        .tvalid_i   (tvalid_i),
        .lo_valid_i (lo_valid),
        .mix_valid_i(mix_valid),
        .out_valid_i(tvalid_o),
        .out_data_i (tdata_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("mismatch %s expected %h actual %h",
                                        test_name, expected, actual));
        end
    endtask

    // nearest integer of the scaled cosine.
    function automatic int lut_value(input int idx);
        real v;

        v = `DDC_AMP * $cos(2.0 * PI * idx / 1024.0);
        if (v >= 0.0) begin
            return $rtoi(v + 0.5);
        end
        return -$rtoi(0.5 - v);
    endfunction

    function automatic int round_sat_ref(input longint value, input int shift, input int mode);
        longint fl;
        longint frac;
        longint half;
        longint r;

        fl = value >>> shift;
        r  = fl;
        if (shift > 0) begin
            frac = value - (fl <<< shift);
            half = longint'(1) <<< (shift - 1);
            if (mode == 1) begin
                r = (value + half) >>> shift;
            end else if (mode == 2) begin
                if (frac > half || (frac == half && (fl & 1) == 1)) begin
                    r = fl + 1;
                end
            end
        end
        if (r > FULL_POS) begin
            r = FULL_POS;
        end else if (r < FULL_NEG) begin
            r = FULL_NEG;
        end
        return int'(r);
    endfunction

    // mixes one sample against the oscillator at the given phase.
    function automatic iq_sample_t ref_ddc_sample(input iq_sample_t x, input int phase,
                                                  input int mode);
        int         idx;
        int         c;
        int         s;
        longint     prod_i;
        longint     prod_q;
        iq_sample_t y;

        idx    = phase >> (PHASE_W - LUT_W);
        c      = lut_value(idx);
        s      = lut_value((idx + 1024 - 256) % 1024);
        prod_i = longint'(x.i) * c + longint'(x.q) * s;
        prod_q = longint'(x.q) * c - longint'(x.i) * s;
        y.i    = IQ_W'(round_sat_ref(prod_i, 15, mode));
        y.q    = IQ_W'(round_sat_ref(prod_q, 15, mode));
        return y;
    endfunction

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            tvalid_in = 1'b0;
            tdata_in  = iq_sample_t'($random(seed));
        end
    endtask

    task automatic restart(input int mode, input int k, input logic [PHASE_W-1:0] inc,
                           input logic [PHASE_W-1:0] off);
        @(negedge clk);
        en           = 1'b0;
        tvalid_in    = 1'b0;
        round_mode   = round_mode_e'(mode[1:0]);
        decim_log2   = `DDC_DEC_W'(k);
        phase_inc    = inc;
        phase_offset = off;
        model_mode   = mode;
        model_k      = k;
        model_inc    = int'(inc);
        model_off    = int'(off);
        model_phase  = 0;
        blk_sum_i    = 0;
        blk_sum_q    = 0;
        blk_n        = 0;
        repeat (2) @(negedge clk);
        en        = 1'b1;
        out_count = 0;
    endtask

    task automatic send_sample(input iq_sample_t x, input int gap);
        iq_sample_t mixed;
        iq_sample_t avg;
        int         phase;

        @(negedge clk);
        tvalid_in   = 1'b1;
        tdata_in    = x;
        phase       = (model_phase + model_off) % (1 << PHASE_W);
        mixed       = ref_ddc_sample(x, phase, model_mode);
        model_phase = (model_phase + model_inc) % (1 << PHASE_W);
        blk_sum_i   += longint'(mixed.i);
        blk_sum_q   += longint'(mixed.q);
        blk_n++;
        if (blk_n == (1 << model_k)) begin
            avg.i = IQ_W'(round_sat_ref(blk_sum_i, model_k, model_mode));
            avg.q = IQ_W'(round_sat_ref(blk_sum_q, model_k, model_mode));
            exp_q.push_back(avg);
            blk_sum_i = 0;
            blk_sum_q = 0;
            blk_n     = 0;
        end
        idle(gap);
    endtask

    task automatic drain(input int expected_outputs);
        // the last block leaves the DUT three cycles after its last input.
        idle(4);
        check_value({cur_test, "_count"}, expected_outputs, out_count);
    endtask

    task automatic run_case(input string name, input int mode, input int k,
                            input logic [PHASE_W-1:0] inc, input logic [PHASE_W-1:0] off,
                            input int n, input int max_gap, input bit full_scale);
        iq_sample_t x;
        int         gap;

        cur_test = name;
        restart(mode, k, inc, off);
        for (int s = 0; s < n; s++) begin
            if (full_scale) begin
                x.i = ($random(seed) & 1) ? IQ_W'(FULL_POS) : IQ_W'(FULL_NEG);
                x.q = ($random(seed) & 1) ? IQ_W'(FULL_POS) : IQ_W'(FULL_NEG);
            end else begin
                x = iq_sample_t'($random(seed));
            end
            gap = (max_gap == 0) ? 0 : int'($unsigned($random(seed)) % (max_gap + 1));
            send_sample(x, gap);
        end
        drain(n >> k);
    endtask

    // registered outputs as they were before this edge.
    always @(posedge clk) begin
        en_was = en_d;
        en_d   = en;
        if (tvalid_out) begin
            if (!en_was) begin
                stop_with_failure("output strobe appeared while enable was low");
            end else if (exp_q.size() == 0) begin
                stop_with_failure("output strobe appeared with no expected value queued");
            end else begin
                exp_v = exp_q.pop_front();
                check_value(cur_test, exp_v, tdata_out);
                out_count++;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        stop_with_failure("timeout: the run did not finish in the expected time");
    end

    initial begin : main_seq
        logic [PHASE_W-1:0] inc;
        logic [PHASE_W-1:0] off;

        rst_n        = 1'b0;
        en           = 1'b0;
        round_mode   = RND_TRUNC;
        decim_log2   = '0;
        phase_inc    = '0;
        phase_offset = '0;
        tvalid_in    = 1'b0;
        tdata_in     = '0;

        repeat (2) begin
            @(negedge clk);
            check_value(cur_test, 32'd0, {31'd0, tvalid_out});
        end
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_value(cur_test, 32'd0, {31'd0, tvalid_out});
        end

        for (int m = 0; m < 3; m++) begin
            run_case($sformatf("zero_freq_mode%0d", m), m, 0, '0, '0, N_ZERO, 0, 1'b0);
        end

        for (int m = 0; m < 3; m++) begin
            inc = PHASE_W'($random(seed));
            off = PHASE_W'($random(seed));
            run_case($sformatf("random_mix_b2b_mode%0d", m), m, 0, inc, off, N_RAND, 0, 1'b0);
            inc = PHASE_W'($random(seed));
            off = PHASE_W'($random(seed));
            run_case($sformatf("random_mix_gap_mode%0d", m), m, 0, inc, off, N_RAND,
                     MAX_GAP, 1'b0);
        end

        // mode code 3 shows up at k = 3 and k = 7.
        for (int k = 0; k <= MAX_K; k++) begin
            inc = PHASE_W'($random(seed));
            off = PHASE_W'($random(seed));
            run_case($sformatf("decimation_k%0d", k), k % 4, k, inc, off, N_DEC, 2, 1'b0);
        end

        // 45 degrees puts cos and sin both near 0.707.
        for (int m = 0; m < 3; m++) begin
            run_case($sformatf("saturation_mode%0d", m), m, 0, '0, PHASE_W'(2048), N_SAT, 1,
                     1'b1);
        end

        cur_test = "enable_restart";
        inc = PHASE_W'($random(seed));
        off = PHASE_W'($random(seed));
        restart(1, 3, inc, off);
        for (int s = 0; s < N_PARTIAL; s++) begin
            send_sample(iq_sample_t'($random(seed)), 0);
        end
        // partial block lost when enable drops.
        restart(1, 3, inc, off);
        for (int s = 0; s < N_RESTART; s++) begin
            send_sample(iq_sample_t'($random(seed)), s % 2);
        end
        drain(N_RESTART >> 3);

        idle(4);
        if (exp_q.size() != 0) begin
            stop_with_failure($sformatf("%0d expected outputs never arrived", exp_q.size()));
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

//--- files.f
+incdir+include
source/ddc_pkg.sv
source/ddc_nco.sv
source/ddc_mixer.sv
source/ddc_decimator.sv
source/ddc_top.sv
verification/ddc_checker.sv
verification/ddc_tb.sv

//--- Bender.yml
package:
  name: ddc

export_include_dirs:
  - include

sources:
  # design sources, package first.
  - include_dirs:
      - include
    files:
      - source/ddc_pkg.sv
      - source/ddc_nco.sv
      - source/ddc_mixer.sv
      - source/ddc_decimator.sv
      - source/ddc_top.sv

  # testbench and bound assertions.
  - target: test
    include_dirs:
      - include
    files:
      - verification/ddc_checker.sv
      - verification/ddc_tb.sv
